//--- Makefile
TOP := i2sTransmitterTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard design/*.sv) $(wildcard sim/*.sv)
	verilator --binary -j 0 --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

//--- design/audioPkg.sv
// Shared I2S transmit types and frame constants, imported by the RTL and the testbench
`default_nettype none

package audioPkg;

    //------------------------------
    // Sample format
    //------------------------------

    // Audio sample width per channel
    localparam int SAMPLE_BITS = 24;

    // One channel's sample, MSB first on the wire
    typedef logic [SAMPLE_BITS-1:0] sampleT;

    //------------------------------
    // Frame layout
    //------------------------------

    // bclk periods per channel slot
    localparam int SLOT_BITS = 32;

    // bclk periods per stereo frame
    localparam int FRAME_BITS = 2 * SLOT_BITS;

    // Zero fill after each sample, low bits of the slot
    localparam int PAD_BITS = SLOT_BITS - SAMPLE_BITS;

    // Channel carried in the current slot, encoded as the lrclk level
    typedef enum logic {
        chanLeft  = 1'b0,
        chanRight = 1'b1
    } channelE;

endpackage

`default_nettype wire

//--- design/i2sClockGen.sv
// Derives bclk and lrclk from audioClk and emits the per-bit and per-frame strobes
`default_nettype none

module i2sClockGen #(
    // audioClk cycles per bclk half period
    parameter int bclkDiv = 4
) (
    input  wire logic          audioClk,
    input  wire logic          rst,
    output logic               bclk,
    output audioPkg::channelE  lrclk,
    output logic               bitStrobe,
    output logic               frameLoad
);

    import audioPkg::*;

    // Half-period counter width, wide enough for bclkDiv of 1
    localparam int DIV_W = $clog2(bclkDiv + 1);

    // Slot counter covers one full stereo frame
    localparam int SLOT_W = $clog2(FRAME_BITS);

    logic [DIV_W-1:0]  divCnt;
    logic              divDone;
    logic [SLOT_W-1:0] slotCnt;

    //------------------------------
    // Bit clock divider
    //------------------------------

    // Last audioClk cycle of the current bclk phase
    assign divDone = (divCnt == DIV_W'(bclkDiv - 1));

    always_ff @(posedge audioClk)
    begin
        if (rst)
        begin
            divCnt <= '0;
            bclk   <= 1'b0;
        end
        else if (divDone)
        begin
            divCnt <= '0;
            // Flip bclk at the end of every half period
            bclk   <= ~bclk;
        end
        else
        begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Cycle ending in a bclk fall
    // Everything downstream registers on this edge
    assign bitStrobe = divDone && bclk;

    //------------------------------
    // Slot counter and word select
    //------------------------------

    // Counts bclk falls, wraps every frame
    always_ff @(posedge audioClk)
    begin
        if (rst)
        begin
            slotCnt <= '0;
        end
        else if (bitStrobe)
        begin
            slotCnt <= slotCnt + 1'b1;
        end
    end

    // Low for slots 0..31, high for slots 32..63
    assign lrclk = channelE'(slotCnt[SLOT_W-1]);

    // The fall that moves slot 0 to slot 1
    // One bit after the lrclk low edge, so the left MSB goes out here
    assign frameLoad = bitStrobe && (slotCnt == '0);

endmodule

`default_nettype wire

//--- design/i2sSerializer.sv
// Shifts one stereo pair per frame onto sdata in I2S framing and flags FIFO underrun
`default_nettype none

module i2sSerializer (
    input  wire logic             audioClk,
    input  wire logic             rst,
    input  wire logic             bitStrobe,
    input  wire logic             frameLoad,
    input  wire logic             fifoEmpty,
    input  wire audioPkg::sampleT headLeft,
    input  wire audioPkg::sampleT headRight,
    input  wire logic             underrunClear,
    output logic                  fifoPop,
    output logic                  sdata,
    output logic                  underrun
);

    import audioPkg::*;

    // Next frame image, MSB goes out first
    logic [FRAME_BITS-1:0] frameWord;

    // Remaining bits after the MSB
    logic [FRAME_BITS-2:0] shiftReg;

    logic                  frameEmpty;

    //------------------------------
    // Frame assembly
    //------------------------------

    // Nothing queued at this frame boundary
    assign frameEmpty = frameLoad && fifoEmpty;

    // Left slot then right slot, each sample padded low with zeros
    always_comb
    begin
        if (fifoEmpty)
        begin
            // Silence
            frameWord = '0;
        end
        else
        begin
            frameWord = {headLeft, {PAD_BITS{1'b0}}, headRight, {PAD_BITS{1'b0}}};
        end
    end

    // Take the head pair as it is loaded
    assign fifoPop = frameLoad && !fifoEmpty;

    //------------------------------
    // Bit shifter
    //------------------------------

    // Shift data only, first use is the first frameLoad
    always_ff @(posedge audioClk)
    begin
        if (frameLoad)
        begin
            shiftReg <= frameWord[FRAME_BITS-2:0];
        end
        else if (bitStrobe)
        begin
            shiftReg <= {shiftReg[FRAME_BITS-3:0], 1'b0};
        end
    end

    // Changes on the bclk fall, stable at the next rise
    always_ff @(posedge audioClk)
    begin
        if (rst)
        begin
            sdata <= 1'b0;
        end
        else if (frameLoad)
        begin
            sdata <= frameWord[FRAME_BITS-1];
        end
        else if (bitStrobe)
        begin
            sdata <= shiftReg[FRAME_BITS-2];
        end
    end

    //------------------------------
    // Underrun flag
    //------------------------------

    // Sticky until the host clears it, clear wins a tie
    always_ff @(posedge audioClk)
    begin
        if (rst || underrunClear)
        begin
            underrun <= 1'b0;
        end
        else if (frameEmpty)
        begin
            underrun <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/i2sTransmitter.sv
// I2S transmitter top, host writes sample pairs and the codec side gets bclk, lrclk, sdata
`default_nettype none

module i2sTransmitter #(
    // audioClk cycles per bclk half period
    parameter int bclkDiv      = 4,
    // log2 of the FIFO depth in pairs
    parameter int fifoDepthLog = 3
) (
    input  wire logic             audioClk,
    input  wire logic             rst,
    // Host side
    input  wire logic             sampleWrite,
    input  wire audioPkg::sampleT sampleLeft,
    input  wire audioPkg::sampleT sampleRight,
    input  wire logic             underrunClear,
    output logic                  fifoFull,
    output logic                  underrun,
    // Codec side
    output logic                  bclk,
    output audioPkg::channelE     lrclk,
    output logic                  sdata
);

    import audioPkg::*;

    // FIFO to serializer
    logic   fifoEmpty;
    logic   fifoPop;
    sampleT headLeft;
    sampleT headRight;

    // Clock generator to serializer
    logic   bitStrobe;
    logic   frameLoad;

    //------------------------------
    // Sample buffer
    //------------------------------
    sampleFifo #(
        .fifoDepthLog (fifoDepthLog)
    ) u_sampleFifo (
        .audioClk   (audioClk),
        .rst        (rst),
        .writeEn    (sampleWrite),
        .writeLeft  (sampleLeft),
        .writeRight (sampleRight),
        .fifoPop    (fifoPop),
        .headLeft   (headLeft),
        .headRight  (headRight),
        .fifoEmpty  (fifoEmpty),
        .fifoFull   (fifoFull)
    );

    //------------------------------
    // Bit and word clocks
    //------------------------------
    i2sClockGen #(
        .bclkDiv (bclkDiv)
    ) u_i2sClockGen (
        .audioClk  (audioClk),
        .rst       (rst),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .bitStrobe (bitStrobe),
        .frameLoad (frameLoad)
    );

    //------------------------------
    // Serial data out
    //------------------------------
    i2sSerializer u_i2sSerializer (
        .audioClk      (audioClk),
        .rst           (rst),
        .bitStrobe     (bitStrobe),
        .frameLoad     (frameLoad),
        .fifoEmpty     (fifoEmpty),
        .headLeft      (headLeft),
        .headRight     (headRight),
        .underrunClear (underrunClear),
        .fifoPop       (fifoPop),
        .sdata         (sdata),
        .underrun      (underrun)
    );

endmodule

`default_nettype wire

//--- design/sampleFifo.sv
// First-word-fall-through FIFO of stereo sample pairs between the host and the serializer
`default_nettype none

module sampleFifo #(
    // log2 of the number of stored pairs
    parameter int fifoDepthLog = 3
) (
    input  wire logic            audioClk,
    input  wire logic            rst,
    input  wire logic            writeEn,
    input  wire audioPkg::sampleT writeLeft,
    input  wire audioPkg::sampleT writeRight,
    input  wire logic            fifoPop,
    output audioPkg::sampleT     headLeft,
    output audioPkg::sampleT     headRight,
    output logic                 fifoEmpty,
    output logic                 fifoFull
);

    import audioPkg::*;

    localparam int DEPTH = 1 << fifoDepthLog;

    //------------------------------
    // Storage and pointers
    //------------------------------

    // Sample pair storage, one entry per frame
    sampleT memLeft  [DEPTH];
    sampleT memRight [DEPTH];

    // Extra top bit separates full from empty
    logic [fifoDepthLog:0]   wrPtr;
    logic [fifoDepthLog:0]   rdPtr;
    logic [fifoDepthLog-1:0] wrAddr;
    logic [fifoDepthLog-1:0] rdAddr;
    logic                    writeAccept;

    assign wrAddr = wrPtr[fifoDepthLog-1:0];
    assign rdAddr = rdPtr[fifoDepthLog-1:0];

    //------------------------------
    // Status
    //------------------------------

    // Same lap, same slot
    assign fifoEmpty = (wrPtr == rdPtr);

    // Writer one lap ahead
    assign fifoFull = (wrPtr[fifoDepthLog] != rdPtr[fifoDepthLog])
                   && (wrAddr == rdAddr);

    // Writes into a full FIFO are dropped here
    assign writeAccept = writeEn && !fifoFull;

    //------------------------------
    // Write side
    //------------------------------

    // Data array, no reset
    always_ff @(posedge audioClk)
    begin
        if (writeAccept)
        begin
            memLeft[wrAddr]  <= writeLeft;
            memRight[wrAddr] <= writeRight;
        end
    end

    always_ff @(posedge audioClk)
    begin
        if (rst)
        begin
            wrPtr <= '0;
        end
        else if (writeAccept)
        begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    //------------------------------
    // Read side
    //------------------------------

    // Pop is trusted, serializer only pops when not empty
    always_ff @(posedge audioClk)
    begin
        if (rst)
        begin
            rdPtr <= '0;
        end
        else if (fifoPop)
        begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    // Head pair straight from the array
    assign headLeft  = memLeft[rdAddr];
    assign headRight = memRight[rdAddr];

endmodule

`default_nettype wire

//--- sim/i2sTransmitterTb.sv
// Self-checking testbench that runs as the simulation top and drives the I2S transmitter as u_dut
`default_nettype none

module i2sTransmitterTb;

    import audioPkg::*;

    localparam int BCLK_DIV       = 4;
    localparam int FIFO_DEPTH_LOG = 3;
    // One stereo frame in audioClk cycles
    localparam int FRAME_CYCLES   = FRAME_BITS * 2 * BCLK_DIV;
    localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 3500;
    localparam int STREAM_PAIRS   = 20;

    logic    audioClk;
    logic    rst;
    logic    sampleWrite;
    sampleT  sampleLeft;
    sampleT  sampleRight;
    logic    underrunClear;
    logic    fifoFull;
    logic    underrun;
    logic    bclk;
    channelE lrclk;
    logic    sdata;

    // Pairs written but not yet seen on sdata
    sampleT      expLeft[$];
    sampleT      expRight[$];
    // Decoded slots with one entry per frame
    logic [31:0] rxLeftQ[$];
    logic [31:0] rxRightQ[$];
    logic [31:0] rngState;
    logic [31:0] rxAcc;
    logic [31:0] rxSlot;
    logic [31:0] rxLeft;
    logic [31:0] gotLeft;
    logic [31:0] gotRight;
    sampleT      wantLeft;
    sampleT      wantRight;
    logic        rxPrevBclk;
    logic        rxPrimed;
    logic        monPrevBclk;
    logic        gapCheck;
    channelE     rxPrevLr;
    channelE     monPrevLr;
    int          rxBits;
    int          phaseLen;
    int          bclkEdges;
    int          riseCount;
    int          lrEdges;
    int          errorCount;
    int          testStart;
    int          testsRun;
    int          testsFailed;
    int          dataFrames;
    int          silentFrames;
    int          mark;
    int          cycleCount = 0;

    i2sTransmitter #(
        .bclkDiv      (BCLK_DIV),
        .fifoDepthLog (FIFO_DEPTH_LOG)
    ) u_dut (
        .audioClk      (audioClk),
        .rst           (rst),
        .sampleWrite   (sampleWrite),
        .sampleLeft    (sampleLeft),
        .sampleRight   (sampleRight),
        .underrunClear (underrunClear),
        .fifoFull      (fifoFull),
        .underrun      (underrun),
        .bclk          (bclk),
        .lrclk         (lrclk),
        .sdata         (sdata)
    );

    initial
    begin
        audioClk = 1'b0;
        forever #10 audioClk = ~audioClk;
    end

    // Run limit of roughly 40 frames plus slack
    always @(posedge audioClk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    //------------------------------
    // Reference and compare tasks
    //------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sample in the top bits with PAD_BITS zeros below
    function automatic logic [31:0] expectedSlot(input sampleT s);
        return {s, {PAD_BITS{1'b0}}};
    endfunction

    task automatic checkSlot(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
        begin
            $display("Fail at time %0t: %s got %h expected %h", $time, name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkSample(input string name, input sampleT got, input sampleT want);
        if (got !== want)
        begin
            $display("Fail at time %0t: %s got %h expected %h", $time, name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("Fail at time %0t: %s got %b expected %b", $time, name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int want);
        if (got != want)
        begin
            $display("Fail at time %0t: %s got %0d expected %0d", $time, name, got, want);
            errorCount++;
        end
    endtask

    //------------------------------
    // I2S receiver model
    //------------------------------

    // Samples sdata and lrclk on each bclk rise
    always @(negedge audioClk)
    begin
        if (rst)
        begin
            rxPrevBclk = 1'b0;
            rxPrevLr   = chanLeft;
            rxAcc      = '0;
            rxBits     = 0;
            rxPrimed   = 1'b0;
        end
        else
        begin
            if (bclk && !rxPrevBclk)
            begin
                if (lrclk != rxPrevLr)
                begin
                    // With the one-bit delay this bit is the LSB of the slot just ended
                    rxSlot = {rxAcc[30:0], sdata};
                    if (rxPrimed)
                        checkCount("bits per slot", rxBits + 1, SLOT_BITS);
                    if (rxPrevLr == chanLeft)
                        rxLeft = rxSlot;
                    else if (rxPrimed)
                    begin
                        rxLeftQ.push_back(rxLeft);
                        rxRightQ.push_back(rxSlot);
                    end
                    rxPrimed = 1'b1;
                    rxAcc    = '0;
                    rxBits   = 0;
                    rxPrevLr = lrclk;
                end
                else
                begin
                    rxAcc  = {rxAcc[30:0], sdata};
                    rxBits = rxBits + 1;
                end
            end
            rxPrevBclk = bclk;
        end
    end

    // Frame checker where silence means both slots zero
    always @(negedge audioClk)
    begin
        if (rxLeftQ.size() > 0)
        begin
            gotLeft  = rxLeftQ.pop_front();
            gotRight = rxRightQ.pop_front();
            if (gotLeft == '0 && gotRight == '0)
            begin
                silentFrames++;
                if (gapCheck && dataFrames > 0 && expLeft.size() > 0)
                begin
                    $display("Fail at time %0t: silent frame while pairs were queued", $time);
                    errorCount++;
                end
            end
            else if (expLeft.size() == 0)
            begin
                $display("Fail at time %0t: frame %h %h arrived with nothing queued",
                         $time, gotLeft, gotRight);
                errorCount++;
            end
            else
            begin
                wantLeft  = expLeft.pop_front();
                wantRight = expRight.pop_front();
                checkSample("left sample", gotLeft[31:8], wantLeft);
                checkSample("right sample", gotRight[31:8], wantRight);
                checkSlot("left slot", gotLeft, expectedSlot(wantLeft));
                checkSlot("right slot", gotRight, expectedSlot(wantRight));
                dataFrames++;
            end
        end
    end

    // Clock ratio monitor that skips the first phase after reset
    always @(negedge audioClk)
    begin
        if (rst)
        begin
            monPrevBclk = 1'b0;
            monPrevLr   = chanLeft;
            phaseLen    = 0;
            bclkEdges   = 0;
            riseCount   = 0;
            lrEdges     = 0;
        end
        else
        begin
            if (bclk != monPrevBclk)
            begin
                if (bclkEdges > 0)
                    checkCount("bclk phase length", phaseLen, BCLK_DIV);
                bclkEdges++;
                phaseLen = 1;
                if (bclk)
                    riseCount++;
            end
            else
                phaseLen++;
            if (lrclk != monPrevLr)
            begin
                // Word select moves only with bclk low
                checkFlag("bclk at lrclk change", bclk, 1'b0);
                if (lrEdges > 0)
                    checkCount("bclk periods per lrclk level", riseCount, SLOT_BITS);
                lrEdges++;
                riseCount = 0;
            end
            monPrevBclk = bclk;
            monPrevLr   = lrclk;
        end
    end

    //------------------------------
    // Stimulus helpers
    //------------------------------

    task automatic nextSample(output sampleT s);
        rngState = xorshift(rngState);
        s = rngState[SAMPLE_BITS-1:0];
        // Zero pair would read as silence
        if (s == '0)
            s = sampleT'(1);
    endtask

    // Drives one write in the current cycle
    task automatic writePair(input logic expectAccept);
        sampleT newLeft;
        sampleT newRight;
        nextSample(newLeft);
        nextSample(newRight);
        sampleWrite = 1'b1;
        sampleLeft  = newLeft;
        sampleRight = newRight;
        if (expectAccept)
        begin
            expLeft.push_back(newLeft);
            expRight.push_back(newRight);
        end
    endtask

    task automatic waitLrFall();
        wait (lrclk == chanRight);
        wait (lrclk == chanLeft);
        @(negedge audioClk);
    endtask

    task automatic pulseClear();
        @(negedge audioClk);
        underrunClear = 1'b1;
        @(negedge audioClk);
        underrunClear = 1'b0;
    endtask

    task automatic checkResetState();
        checkFlag("bclk", bclk, 1'b0);
        checkFlag("lrclk", lrclk, 1'b0);
        checkFlag("sdata", sdata, 1'b0);
        checkFlag("fifoFull", fifoFull, 1'b0);
        checkFlag("underrun", underrun, 1'b0);
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errorCount != testStart)
            testsFailed++;
        $display("Test %0d %s: %s, %0d errors", testsRun, name,
                 (errorCount == testStart) ? "ok" : "failed", errorCount - testStart);
        testStart = errorCount;
    endtask

    //------------------------------
    // Test sequence
    //------------------------------

    initial
    begin
        rst           = 1'b1;
        sampleWrite   = 1'b0;
        sampleLeft    = '0;
        sampleRight   = '0;
        underrunClear = 1'b0;
        rngState      = 32'hf1d237f0;
        errorCount    = 0;
        testStart     = 0;
        testsRun      = 0;
        testsFailed   = 0;
        dataFrames    = 0;
        silentFrames  = 0;
        gapCheck      = 1'b0;

        // Reset state checked inside and just after reset
        repeat (5) @(negedge audioClk);
        checkResetState();
        repeat (5) @(negedge audioClk);
        rst = 1'b0;
        @(negedge audioClk);
        checkResetState();
        endTest("reset state");

        // The monitor checks phase lengths while idle
        waitLrFall();
        mark = cycleCount;
        // Two whole frames between lrclk falls
        repeat (2) waitLrFall();
        checkCount("cycles per two frames", cycleCount - mark, 2 * FRAME_CYCLES);
        endTest("clock ratios");

        // Prefill and then one pair per frame keeps the FIFO busy
        repeat (6)
        begin
            @(negedge audioClk);
            writePair(1'b1);
        end
        @(negedge audioClk);
        sampleWrite = 1'b0;
        repeat (2) waitLrFall();
        pulseClear();
        gapCheck = 1'b1;
        for (int i = 6; i < STREAM_PAIRS; i++)
        begin
            waitLrFall();
            writePair(1'b1);
            @(negedge audioClk);
            sampleWrite = 1'b0;
        end
        while (expLeft.size() > 0)
            @(negedge audioClk);
        checkFlag("underrun", underrun, 1'b0);
        checkCount("pairs received", dataFrames, STREAM_PAIRS);
        gapCheck = 1'b0;
        endTest("streaming");

        // Once drained, silent frames must raise underrun
        mark = silentFrames;
        while (silentFrames < mark + 2)
            @(negedge audioClk);
        checkFlag("underrun", underrun, 1'b1);
        // Clear away from a frame boundary
        waitLrFall();
        repeat (12) @(negedge audioClk);
        pulseClear();
        checkFlag("underrun", underrun, 1'b0);
        waitLrFall();
        checkFlag("underrun", underrun, 1'b0);
        // Past the next frameLoad
        repeat (12) @(negedge audioClk);
        checkFlag("underrun", underrun, 1'b1);
        endTest("underrun");

        // Nine back to back writes in the right slot with the ninth dropped
        wait (lrclk == chanLeft);
        wait (lrclk == chanRight);
        for (int i = 1; i <= 9; i++)
        begin
            @(negedge audioClk);
            checkFlag("fifoFull", fifoFull, i == 9);
            writePair(i <= 8);
        end
        @(negedge audioClk);
        sampleWrite = 1'b0;
        checkFlag("fifoFull", fifoFull, 1'b1);
        // No silence between the eight once the first has arrived
        while (dataFrames < STREAM_PAIRS + 1)
            @(negedge audioClk);
        gapCheck = 1'b1;
        while (expLeft.size() > 0)
            @(negedge audioClk);
        gapCheck = 1'b0;
        mark = silentFrames;
        while (silentFrames < mark + 1)
            @(negedge audioClk);
        checkCount("pairs received", dataFrames, STREAM_PAIRS + 8);
        endTest("full and dropped writes");

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/audioPkg.sv
design/sampleFifo.sv
design/i2sClockGen.sv
design/i2sSerializer.sv
design/i2sTransmitter.sv
sim/i2sTransmitterTb.sv
